//--- rtl/cache_bus_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, flash region code and burst codes
// for the cache line bridge. include in any
// file that needs one of these constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CACHE_BUS_DEFINES_SVH
`define CACHE_BUS_DEFINES_SVH

`define CB_ADDR_W       64     // byte address width
`define CB_LINE_W       512    // one cache line, 64 bytes

`define CB_FLASH_CODE   4'h8   // addr[31:28] value of the flash window
`define CB_FLASH_BEATS  16     // 32-bit beats per line on flash

// burst codes, number of 64-bit blocks minus one
`define CB_MEM_BLKS     8'd7
`define CB_FLASH_BLKS   8'd0

`endif

//--- rtl/cache_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types shared by the bridge modules and
// the testbench. import with cache_bus_pkg::*
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "cache_bus_defines.svh"

package cache_bus_pkg;

  typedef logic [`CB_ADDR_W-1:0] addr_t;   // byte address
  typedef logic [`CB_LINE_W-1:0] line_t;   // whole cache line
  typedef logic [31:0]           word_t;   // one flash word

  // bus transfer size, axi style log2 of bytes
  typedef enum logic [1:0] {
    SIZE_W = 2'd2,   // 4 bytes, flash
    SIZE_D = 2'd3    // 8 bytes, main memory blocks
  } bus_size_t;

  // word slot inside a line during a flash transfer
  typedef logic [3:0] beat_idx_t;

endpackage

`default_nettype wire

//--- rtl/line_req_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// latched line request, decode -> execute
// fields only move on start, busy holds off
// the next start until the bus side is done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface line_req_if;
  import cache_bus_pkg::*;

  logic  start;   // one cycle strobe
  addr_t addr;    // already aligned for the region
  logic  op;      // 0 read, 1 write
  logic  flash;   // flash region, 32-bit single beats
  line_t wdata;   // line to write back
  logic  busy;    // bus side still working

  modport dec (output start, addr, op, flash, wdata, input busy);
  modport exe (input start, addr, op, flash, wdata, output busy);

endinterface

`default_nettype wire

//--- rtl/beat_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// completed bus beats, execute -> result
// valid pulses once per bus handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface beat_if;
  import cache_bus_pkg::*;

  logic      valid;   // handshake this cycle
  beat_idx_t idx;     // word slot for narrow beats
  logic      wide;    // memory beat, whole line
  logic      last;    // final beat of the line
  line_t     data;    // raw bus read data

  modport exe (output valid, idx, wide, last, data);
  modport res (input valid, idx, wide, last, data);

endinterface

`default_nettype wire

//--- rtl/req_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache side front end. waits for req on two
// consecutive cycles, picks the region, aligns
// the address and latches the request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "cache_bus_defines.svh"

module req_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_req,
  input  cache_bus_pkg::addr_t i_addr,
  input  logic                 i_op,      // 0 read, 1 write
  input  cache_bus_pkg::line_t i_wdata,
  line_req_if.dec              req
);
  import cache_bus_pkg::*;

  logic  req_his;        // req seen last cycle
  logic  start_q;
  logic  is_flash;
  logic  take;           // accept the request this edge
  addr_t aligned_addr;
  addr_t addr_q;
  logic  op_q;
  logic  flash_q;
  line_t wdata_q;

  assign is_flash = (i_addr[31:28] == `CB_FLASH_CODE);

  // flash moves words, memory moves whole lines
  always_comb begin
    if (is_flash) begin
      aligned_addr = {i_addr[`CB_ADDR_W-1:2], 2'b00};
    end else begin
      aligned_addr = {i_addr[`CB_ADDR_W-1:6], 6'd0};
    end
  end

  // start_q term keeps the edge right after start quiet, busy is not up yet
  assign take = i_req & req_his & ~req.busy & ~start_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_his <= 1'b0;
      start_q <= 1'b0;
    end else begin
      req_his <= i_req & ~req.busy;   // history wiped while busy
      start_q <= take;
    end
  end

  // payload, only moves when a request is taken
  always_ff @(posedge clk) begin
    if (take) begin
      addr_q  <= aligned_addr;
      op_q    <= i_op;
      flash_q <= is_flash;
      wdata_q <= i_wdata;
    end
  end

  assign req.start = start_q;
  assign req.addr  = addr_q;
  assign req.op    = op_q;
  assign req.flash = flash_q;
  assign req.wdata = wdata_q;

  // execute owns busy, so this checks the hand-off between the two
  a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
    req.start |-> !req.busy)
    else $error("start raised while the bus side is busy");

endmodule

`default_nettype wire

//--- rtl/bus_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus side engine. runs the valid/ready
// handshake for one line, 16 word beats on
// flash or one 512-bit beat on memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "cache_bus_defines.svh"

module bus_execute (
  input  logic                      clk,
  input  logic                      rst,
  line_req_if.exe                   req,
  beat_if.exe                       beat,
  output logic                      o_bus_valid,
  input  logic                      i_bus_ready,
  output logic                      o_bus_op,     // 0 read, 1 write
  output cache_bus_pkg::addr_t      o_bus_addr,
  output cache_bus_pkg::line_t      o_bus_wdata,
  output cache_bus_pkg::bus_size_t  o_bus_size,
  output logic [7:0]                o_bus_blks,
  input  cache_bus_pkg::line_t      i_bus_rdata
);
  import cache_bus_pkg::*;

  logic      active;     // valid toward the bus
  logic      hs;         // handshake this edge
  logic      last_beat;
  beat_idx_t cnt;        // flash word counter
  addr_t     addr_q;
  word_t     cur_word;   // flash write word for this beat

  assign hs = active & i_bus_ready;

  // memory is always a single beat
  assign last_beat = ~req.flash | (cnt == beat_idx_t'(`CB_FLASH_BEATS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      cnt    <= '0;
    end else if (req.start) begin
      active <= 1'b1;
      cnt    <= '0;
    end else if (hs) begin
      if (last_beat) begin
        active <= 1'b0;            // line done, drop valid
      end else begin
        cnt <= cnt + beat_idx_t'(1);
      end
    end
  end

  // address only steps after a handshake, so it holds under stall
  always_ff @(posedge clk) begin
    if (req.start) begin
      addr_q <= req.addr;
    end else if (hs && !last_beat) begin
      addr_q <= addr_q + addr_t'(4);
    end
  end

  // word n of the line rides in the low bits on flash beat n
  assign cur_word = req.wdata[{cnt, 5'd0} +: 32];

  assign o_bus_valid = active;
  assign o_bus_op    = req.op;
  assign o_bus_addr  = addr_q;
  assign o_bus_wdata = req.flash ? {{(`CB_LINE_W-32){1'b0}}, cur_word} : req.wdata;
  assign o_bus_size  = req.flash ? SIZE_W : SIZE_D;
  assign o_bus_blks  = req.flash ? `CB_FLASH_BLKS : `CB_MEM_BLKS;

  assign req.busy = active;   // falls at the last handshake edge

  // beat report straight from the handshake
  assign beat.valid = hs;
  assign beat.idx   = cnt;
  assign beat.wide  = ~req.flash;
  assign beat.last  = last_beat;
  assign beat.data  = i_bus_rdata;

  // valid may only drop after the slave took the beat
  a_valid_holds: assert property (@(posedge clk) disable iff (rst)
    o_bus_valid && !i_bus_ready |=> o_bus_valid)
    else $error("bus valid dropped without a handshake");

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    o_bus_valid && !i_bus_ready |=> $stable(o_bus_addr) && $stable(o_bus_wdata))
    else $error("bus address or write data moved during a stall");

endmodule

`default_nettype wire

//--- rtl/line_result.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// builds the returned line from bus beats
// and pulses ack once the last beat is in.
// rdata holds until the next line completes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module line_result (
  input  logic                 clk,
  input  logic                 rst,
  beat_if.res                  beat,
  output cache_bus_pkg::line_t o_rdata,
  output logic                 o_ack
);
  import cache_bus_pkg::*;

  line_t line_buf;    // line under assembly
  line_t merged;      // buffer with this beat applied
  word_t beat_word;

  assign beat_word = beat.data[31:0];   // flash data sits in the low word

  always_comb begin
    merged = line_buf;
    if (beat.wide) begin
      merged = beat.data;
    end else begin
      merged[{beat.idx, 5'd0} +: 32] = beat_word;
    end
  end

  // payload regs, every word is overwritten each line
  always_ff @(posedge clk) begin
    if (beat.valid) begin
      line_buf <= merged;
    end
    if (beat.valid && beat.last) begin
      o_rdata <= merged;   // last beat goes in like the rest
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= beat.valid & beat.last;
    end
  end

  // one ack per line, cache drops req on it
  a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    o_ack |=> !o_ack)
    else $error("ack held for more than one cycle");

endmodule

`default_nettype wire

//--- rtl/cache_bus_bridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache line bridge top. cache req/ack on
// one side, valid/ready system bus on the
// other. decode -> execute -> result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module cache_bus_bridge (
  input  logic                      clk,
  input  logic                      rst,
  // cache side
  input  logic                      i_req,
  input  cache_bus_pkg::addr_t      i_addr,
  input  logic                      i_op,
  input  cache_bus_pkg::line_t      i_wdata,
  output cache_bus_pkg::line_t      o_rdata,
  output logic                      o_ack,
  // system bus
  output logic                      o_bus_valid,
  input  logic                      i_bus_ready,
  output logic                      o_bus_op,
  output cache_bus_pkg::addr_t      o_bus_addr,
  output cache_bus_pkg::line_t      o_bus_wdata,
  output cache_bus_pkg::bus_size_t  o_bus_size,
  output logic [7:0]                o_bus_blks,
  input  cache_bus_pkg::line_t      i_bus_rdata
);
  import cache_bus_pkg::*;

  line_req_if lreq ();   // latched request
  beat_if     beat ();   // per handshake beats

  req_decode u_decode (
    .clk     (clk),
    .rst     (rst),
    .i_req   (i_req),
    .i_addr  (i_addr),
    .i_op    (i_op),
    .i_wdata (i_wdata),
    .req     (lreq.dec)
  );

  bus_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .req         (lreq.exe),
    .beat        (beat.exe),
    .o_bus_valid (o_bus_valid),
    .i_bus_ready (i_bus_ready),
    .o_bus_op    (o_bus_op),
    .o_bus_addr  (o_bus_addr),
    .o_bus_wdata (o_bus_wdata),
    .o_bus_size  (o_bus_size),
    .o_bus_blks  (o_bus_blks),
    .i_bus_rdata (i_bus_rdata)
  );

  line_result u_result (
    .clk     (clk),
    .rst     (rst),
    .beat    (beat.res),
    .o_rdata (o_rdata),
    .o_ack   (o_ack)
  );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// free running clock, reset high for the
// first few rising edges, then released
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;   // 50 ns half period
  end

  // sync release on a rising edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tests/tb_bus_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system bus slave for the bridge testbench
// random ready stalls from an lcg, read data
// from a fixed address rule, and a log of
// every handshake for the checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_bus_model (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_valid,
  input  logic                      i_op,
  input  cache_bus_pkg::addr_t      i_addr,
  input  cache_bus_pkg::line_t      i_wdata,
  input  cache_bus_pkg::bus_size_t  i_size,
  input  logic [7:0]                i_blks,
  output logic                      o_ready,
  output cache_bus_pkg::line_t      o_rdata
);
  import cache_bus_pkg::*;

  localparam int          LOG_DEPTH = 256;
  localparam logic [31:0] RD_MASK   = 32'h5a5a_0000;   // word = addr xor mask

  logic [31:0] lcg_state;
  logic [1:0]  wait_cnt;    // stall cycles left before ready
  logic [1:0]  delay;       // next stall length, 0 to 3

  // handshake log, read by the top through hierarchy
  addr_t       log_addr [LOG_DEPTH];
  logic        log_op   [LOG_DEPTH];
  bus_size_t   log_size [LOG_DEPTH];
  logic [7:0]  log_blks [LOG_DEPTH];
  line_t       log_data [LOG_DEPTH];
  logic [8:0]  log_cnt;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // 16 consecutive words from the beat address up
  function automatic line_t read_line(input addr_t a);
    line_t l;
    for (int k = 0; k < 16; k++) begin
      l[32*k +: 32] = (a[31:0] + 32'(4 * k)) ^ RD_MASK;
    end
    return l;
  endfunction

  assign o_rdata = read_line(i_addr);   // flash only uses the low word
  assign delay   = lcg_state[17:16];    // upper bits, low ones cycle fast

  always @(posedge clk) begin
    if (rst) begin
      lcg_state <= 32'hc467;
      wait_cnt  <= 2'd0;
      o_ready   <= 1'b0;
      log_cnt   <= 9'd0;
    end else if (i_valid && o_ready) begin
      lcg_state <= lcg_next(lcg_state);   // new stall after each beat
      wait_cnt  <= delay;
      o_ready   <= (delay == 2'd0);
      if (!log_cnt[8]) begin
        log_addr[log_cnt[7:0]] <= i_addr;
        log_op[log_cnt[7:0]]   <= i_op;
        log_size[log_cnt[7:0]] <= i_size;
        log_blks[log_cnt[7:0]] <= i_blks;
        log_data[log_cnt[7:0]] <= i_wdata;
        log_cnt                <= log_cnt + 9'd1;
      end
    end else if (wait_cnt != 2'd0) begin
      if (i_valid) begin                  // stall only counts while valid
        wait_cnt <= wait_cnt - 2'd1;
        o_ready  <= (wait_cnt == 2'd1);
      end
    end else begin
      o_ready <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_cache_bus_bridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top for the cache line bridge
// runs a table of line requests through the
// dut and checks the bus log, read line,
// ack pulses and stall stability
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_cache_bus_bridge;
  import cache_bus_pkg::*;

  localparam int          NUM_TESTS   = 9;
  localparam int          RST_CYCLES  = 4;
  localparam int          CYCLE_LIMIT = 40 * NUM_TESTS + RST_CYCLES;
  localparam logic [31:0] RD_MASK     = 32'h5a5a_0000;

  logic      clk;
  logic      rst;
  logic      req;
  addr_t     addr;
  logic      op;
  line_t     wdata;
  line_t     rdata;
  logic      ack;
  logic      bus_valid;
  logic      bus_ready;
  logic      bus_op;
  addr_t     bus_addr;
  line_t     bus_wdata;
  bus_size_t bus_size;
  logic [7:0] bus_blks;
  line_t     bus_rdata;

  // stimulus table
  string       t_name  [NUM_TESTS];
  logic        t_pulse [NUM_TESTS];   // single cycle req with no transfer
  logic        t_op    [NUM_TESTS];
  addr_t       t_addr  [NUM_TESTS];
  logic [31:0] t_seed  [NUM_TESTS];   // wdata seed
  int          t_fill = 0;

  string cur_name = "none";
  int    err_cnt  = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;
  int    ack_cnt  = 0;
  int    cycle_cnt = 0;
  logic  stall_q;
  addr_t hold_addr;
  line_t hold_wdata;

  tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(RST_CYCLES)) i_clk (.clk(clk), .rst(rst));

  cache_bus_bridge i_dut (
    .clk         (clk),
    .rst         (rst),
    .i_req       (req),
    .i_addr      (addr),
    .i_op        (op),
    .i_wdata     (wdata),
    .o_rdata     (rdata),
    .o_ack       (ack),
    .o_bus_valid (bus_valid),
    .i_bus_ready (bus_ready),
    .o_bus_op    (bus_op),
    .o_bus_addr  (bus_addr),
    .o_bus_wdata (bus_wdata),
    .o_bus_size  (bus_size),
    .o_bus_blks  (bus_blks),
    .i_bus_rdata (bus_rdata)
  );

  tb_bus_model i_bus (
    .clk     (clk),
    .rst     (rst),
    .i_valid (bus_valid),
    .i_op    (bus_op),
    .i_addr  (bus_addr),
    .i_wdata (bus_wdata),
    .i_size  (bus_size),
    .i_blks  (bus_blks),
    .o_ready (bus_ready),
    .o_rdata (bus_rdata)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic line_t make_line(input logic [31:0] seed);
    line_t       l;
    logic [31:0] w;
    w = seed;
    for (int k = 0; k < 16; k++) begin
      w = lcg_next(w);
      l[32*k +: 32] = w;
    end
    return l;
  endfunction

  task automatic add_test(input string name, input logic pulse, input logic wr,
                          input addr_t a, input logic [31:0] seed);
    t_name[t_fill]  = name;
    t_pulse[t_fill] = pulse;
    t_op[t_fill]    = wr;
    t_addr[t_fill]  = a;
    t_seed[t_fill]  = seed;
    t_fill++;
  endtask

  task automatic check_num(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("ERROR %s %s: expected %h, actual %h", cur_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_line(input string what, input line_t exp, input line_t act);
    assert (exp === act) else begin
      $display("ERROR %s %s: expected %h, actual %h", cur_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_test(input int err_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("test %-18s passed", cur_name);
    end else begin
      fail_cnt++;
      $display("test %-18s failed with %0d errors", cur_name, err_cnt - err_before);
    end
  endtask

  // ack and valid stay low through reset and just after
  task automatic check_reset();
    int err_before;
    err_before = err_cnt;
    cur_name = "reset";
    @(negedge clk);
    while (rst === 1'b1) begin
      check_num("ack in reset", 64'd0, 64'(ack));
      check_num("valid in reset", 64'd0, 64'(bus_valid));
      @(negedge clk);
    end
    check_num("ack after reset", 64'd0, 64'(ack));
    check_num("valid after reset", 64'd0, 64'(bus_valid));
    report_test(err_before);
  endtask

  // one cycle req must not start the bridge
  task automatic check_pulse(input int t);
    int base;
    base = int'(i_bus.log_cnt);
    @(posedge clk);
    req  <= 1'b1;
    addr <= t_addr[t];
    op   <= t_op[t];
    @(posedge clk);
    req <= 1'b0;
    repeat (6) begin
      @(posedge clk);
      check_num("bus valid", 64'd0, 64'(bus_valid));
      check_num("ack", 64'd0, 64'(ack));
    end
    check_num("beat count", 64'd0, 64'(int'(i_bus.log_cnt) - base));
  endtask

  task automatic run_line(input int t);
    addr_t      aligned;
    line_t      wline;
    line_t      exp_line;
    line_t      got;
    logic       flash;
    int         base;
    int         ack_base;
    int         nbeats;
    logic [7:0] slot;
    flash    = (t_addr[t][31:28] == 4'h8);
    aligned  = flash ? {t_addr[t][63:2], 2'b00} : {t_addr[t][63:6], 6'd0};
    nbeats   = flash ? 16 : 1;
    wline    = make_line(t_seed[t]);
    base     = int'(i_bus.log_cnt);
    ack_base = ack_cnt;
    @(posedge clk);
    req   <= 1'b1;
    addr  <= t_addr[t];
    op    <= t_op[t];
    wdata <= wline;
    @(posedge clk);
    while (ack !== 1'b1) @(posedge clk);   // run limit guards a hang
    got = rdata;
    req <= 1'b0;                           // cache drops req on ack
    repeat (2) begin                       // room for a stray second ack
      @(posedge clk);
      check_num("valid after ack", 64'd0, 64'(bus_valid));   // no restart
    end
    check_num("beat count", 64'(nbeats), 64'(int'(i_bus.log_cnt) - base));
    for (int n = 0; n < nbeats; n++) begin
      slot = 8'(base + n);
      check_num("beat addr", aligned + 64'(4 * n), i_bus.log_addr[slot]);
      check_num("bus size", 64'(flash ? SIZE_W : SIZE_D), 64'(i_bus.log_size[slot]));
      check_num("burst code", flash ? 64'd0 : 64'd7, 64'(i_bus.log_blks[slot]));
      check_num("bus op", 64'(t_op[t]), 64'(i_bus.log_op[slot]));
      if (t_op[t]) begin
        if (flash) begin
          // word n of the line in the low bits
          check_num("write word", 64'(wline[32*n +: 32]),
                    64'(i_bus.log_data[slot][31:0]));
        end else begin
          check_line("write data", wline, i_bus.log_data[slot]);
        end
      end
    end
    if (!t_op[t]) begin
      for (int k = 0; k < 16; k++) begin
        exp_line[32*k +: 32] = (aligned[31:0] + 32'(4 * k)) ^ RD_MASK;
      end
      check_line("read line", exp_line, got);
    end
    check_num("ack pulses", 64'd1, 64'(ack_cnt - ack_base));
  endtask

  // bus side monitor for stall stability and ack count
  always @(posedge clk) begin
    if (rst) begin
      stall_q <= 1'b0;
    end else begin
      if (ack) ack_cnt <= ack_cnt + 1;
      if (stall_q && bus_valid) begin
        assert (bus_addr == hold_addr) else begin
          $display("ERROR %s stall addr: expected %h, actual %h", cur_name, hold_addr, bus_addr);
          err_cnt++;
        end
        assert (bus_wdata == hold_wdata) else begin
          $display("ERROR %s stall wdata: expected %h, actual %h",
                   cur_name, hold_wdata, bus_wdata);
          err_cnt++;
        end
      end
      stall_q    <= bus_valid && !bus_ready;
      hold_addr  <= bus_addr;
      hold_wdata <= bus_wdata;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int err_before;
    req   = 1'b0;
    addr  = '0;
    op    = 1'b0;
    wdata = '0;
    add_test("pulse_no_start",   1'b1, 1'b0, 64'h0000_0000_1000_0000, 32'h0);
    add_test("mem_rd_unaligned", 1'b0, 1'b0, 64'h0000_0000_2000_1234, 32'h0);
    add_test("flash_rd",         1'b0, 1'b0, 64'h0000_0000_8000_0106, 32'h0);
    add_test("mem_wr",           1'b0, 1'b1, 64'h0000_0001_4000_0047, 32'h1111);
    add_test("flash_wr",         1'b0, 1'b1, 64'h0000_0000_8000_2002, 32'h2222);
    add_test("mem_rd_top",       1'b0, 1'b0, 64'h0000_0000_7fff_ffff, 32'h0);
    add_test("flash_rd_cross",   1'b0, 1'b0, 64'h0000_0000_8fff_ffe1, 32'h0);
    add_test("mem_wr_high",      1'b0, 1'b1, 64'hffff_ffff_0000_00c0, 32'h3333);
    add_test("flash_wr_high",    1'b0, 1'b1, 64'h1234_5678_8765_4323, 32'h4444);
    check_reset();
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_name   = t_name[t];
      err_before = err_cnt;
      if (t_pulse[t]) begin
        check_pulse(t);
      end else begin
        run_line(t);
      end
      report_test(err_before);
    end
    $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+rtl
rtl/cache_bus_pkg.sv
rtl/line_req_if.sv
rtl/beat_if.sv
rtl/req_decode.sv
rtl/bus_execute.sv
rtl/line_result.sv
rtl/cache_bus_bridge.sv
tests/tb_clk_gen.sv
tests/tb_bus_model.sv
tests/tb_cache_bus_bridge.sv

//--- Makefile
# Verilator build for the cache line bridge testbench

VERILATOR  ?= verilator
TOP        := tb_cache_bus_bridge
FILELIST   := tb.f
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
